//--- sim.f
design/sum_kernel_pkg.sv
design/result_fifo.sv
design/edge_sum_accumulator.sv
design/sum_kernel_control.sv
design/kernel_config_regs.sv
design/sum_kernel_top.sv
testbench/sum_kernel_tb.sv

//--- Makefile
# Verilator build, run and lint for the sum compute unit
# the run target fails when the testbench stops with $fatal

VERILATOR  ?= verilator
TOP        ?= sum_kernel_tb
RTL_TOP    ?= sum_kernel_top
FILELIST   ?= sim.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/sum_kernel_tb.sv
// directed testbench for one sum compute unit
// plays the job source, the edge memory and the write-bus arbiter,
// then checks result records and config readback against its own sums

`timescale 1ns/100ps

module sum_kernel_tb
	import sum_kernel_pkg::*;
();

	localparam int          CU_X       = 3;
	localparam int          CU_Y       = 5;
	localparam int          FIFO_DEPTH = 4;
	localparam int          TIMEOUT    = 1000;
	localparam logic [31:0] SEED       = 32'h66b4_e2da;

	logic        clock;
	logic        rstn;
	vertex_job_t vertex_job;
	logic        vertex_valid;
	logic        vertex_ready;
	edge_word_t  edge_word;
	logic        edge_valid;
	logic        edge_ready;
	logic        write_request;
	logic        write_grant;
	result_rec_t result_out;
	logic        result_valid;
	cfg_req_t    cfg_req;
	logic        cfg_valid;
	logic [31:0] cfg_rdata;
	logic        cfg_rvalid;

	// grant modes: 0 never, 1 every cycle, 2 random gaps
	int          grant_mode;
	logic [31:0] pending_words[$];
	result_rec_t exp_q[$];
	result_rec_t got_q[$];
	logic        pop_seen;
	logic        prev_valid;
	int          edges_sent;
	int          results_seen;
	string       test_name;

	sum_kernel_top #(
		.CU_ID_X          (CU_X),
		.CU_ID_Y          (CU_Y),
		.RESULT_FIFO_DEPTH(FIFO_DEPTH)
	) u_dut (
		.clock        (clock),
		.rstn         (rstn),
		.vertex_job   (vertex_job),
		.vertex_valid (vertex_valid),
		.vertex_ready (vertex_ready),
		.edge_word    (edge_word),
		.edge_valid   (edge_valid),
		.edge_ready   (edge_ready),
		.write_request(write_request),
		.write_grant  (write_grant),
		.result_out   (result_out),
		.result_valid (result_valid),
		.cfg_req      (cfg_req),
		.cfg_valid    (cfg_valid),
		.cfg_rdata    (cfg_rdata),
		.cfg_rvalid   (cfg_rvalid)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	//////////////////////////////////////////////////
	// bus arbiter model and result monitor
	//////////////////////////////////////////////////

	always begin
		int mode;
		int roll;
		@(posedge clock);
		mode = grant_mode;
		roll = int'($urandom % 3);
		#2;
		write_grant = (mode == 1) || (mode == 2 && roll == 0);
	end

	// a pop seen at one edge must show up as result_valid right after it
	always @(negedge clock) begin
		if (!rstn) begin
			pop_seen   = 1'b0;
			prev_valid = 1'b0;
		end else begin
			if (result_valid !== pop_seen)
				stop_run($sformatf("result_valid in %s did not follow a granted request",
					test_name));
			if (result_valid && prev_valid)
				stop_run($sformatf("result_valid in %s lasted more than one cycle", test_name));
			if (result_valid)
				got_q.push_back(result_out);
			prev_valid = result_valid;
			pop_seen   = write_request && write_grant;
		end
	end

	//////////////////////////////////////////////////
	// helpers and checks
	//////////////////////////////////////////////////

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("TEST FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic step();
		@(posedge clock);
		#2;
	endtask

	task automatic wait_step(inout int waited, input string what);
		step();
		waited++;
		if (waited > TIMEOUT)
			stop_run($sformatf("timeout in %s while waiting for %s", test_name, what));
	endtask

	task automatic compare_result(input string name, input result_rec_t exp,
		input result_rec_t act);
		if (act !== exp)
			stop_run($sformatf("FAIL %s expected %h actual %h", name, exp, act));
	endtask

	task automatic compare_word(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp)
			stop_run($sformatf("FAIL %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_outputs_low(input string name);
		compare_word(name, 32'd0, {29'b0, vertex_ready, edge_ready, write_request});
	endtask

	task automatic make_words(input int n);
		pending_words.delete();
		repeat (n) pending_words.push_back($urandom);
	endtask

	// reference record: wrapping sum of the words, stamped with the unit ids
	task automatic queue_expected(input logic [VERTEX_ID_BITS-1:0] vid);
		result_rec_t rec;
		rec            = '0;
		rec.vertex_id  = vid;
		rec.cu_id_x    = CU_ID_BITS'(CU_X);
		rec.cu_id_y    = CU_ID_BITS'(CU_Y);
		rec.edge_count = EDGE_COUNT_BITS'(pending_words.size());
		foreach (pending_words[i])
			rec.sum = rec.sum + pending_words[i];
		exp_q.push_back(rec);
	endtask

	task automatic send_job(input logic [VERTEX_ID_BITS-1:0] vid,
		input logic [EDGE_COUNT_BITS-1:0] degree);
		int waited;
		waited                = 0;
		vertex_job.vertex_id  = vid;
		vertex_job.out_degree = degree;
		vertex_valid          = 1'b1;
		while (!vertex_ready)
			wait_step(waited, "vertex_ready");
		step();
		vertex_valid = 1'b0;
	endtask

	task automatic send_edges(input int first, input int last);
		int waited;
		for (int i = first; i < last; i++) begin
			waited         = 0;
			edge_word.data = pending_words[i];
			edge_valid     = 1'b1;
			while (!edge_ready)
				wait_step(waited, "edge_ready");
			step();
			edges_sent++;
		end
		edge_valid = 1'b0;
	endtask

	task automatic run_job(input logic [VERTEX_ID_BITS-1:0] vid);
		queue_expected(vid);
		send_job(vid, EDGE_COUNT_BITS'(pending_words.size()));
		send_edges(0, pending_words.size());
	endtask

	task automatic check_results();
		int waited;
		waited = 0;
		while (got_q.size() < exp_q.size())
			wait_step(waited, "result records");
		while (exp_q.size() > 0) begin
			compare_result(test_name, exp_q.pop_front(), got_q.pop_front());
			results_seen++;
		end
		compare_word({test_name, " extra records"}, 32'd0, 32'(got_q.size()));
	endtask

	task automatic cfg_write(input logic [1:0] addr, input logic [31:0] data);
		cfg_req.write = 1'b1;
		cfg_req.addr  = addr;
		cfg_req.wdata = data;
		cfg_valid     = 1'b1;
		step();
		cfg_valid     = 1'b0;
		cfg_req.write = 1'b0;
	endtask

	task automatic cfg_read(input logic [1:0] addr, output logic [31:0] data);
		cfg_req.write = 1'b0;
		cfg_req.addr  = addr;
		cfg_valid     = 1'b1;
		step();
		cfg_valid = 1'b0;
		// read data is due exactly one cycle after the access
		if (!cfg_rvalid)
			stop_run($sformatf("cfg_rvalid in %s did not follow the read access", test_name));
		data = cfg_rdata;
	endtask

	//////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////

	task automatic test_reset_disabled();
		logic [31:0] value;
		test_name             = "reset_disabled";
		vertex_job.vertex_id  = 16'h0077;
		vertex_job.out_degree = 16'd2;
		vertex_valid          = 1'b1;
		edge_valid            = 1'b1;
		repeat (5) begin
			check_outputs_low(test_name);
			step();
		end
		vertex_valid = 1'b0;
		edge_valid   = 1'b0;
		cfg_read(CFG_ADDR_CTRL, value);
		compare_word({test_name, " ctrl"}, 32'd0, value);
		cfg_read(CFG_ADDR_EDGES, value);
		compare_word({test_name, " edges"}, 32'd0, value);
	endtask

	task automatic test_single_vertex();
		test_name = "single_vertex";
		cfg_write(CFG_ADDR_CTRL, 32'd1);
		grant_mode = 1;
		make_words(5);
		run_job(16'h0101);
		check_results();
	endtask

	task automatic test_degree_zero_and_wrap();
		test_name = "degree_zero_and_wrap";
		pending_words.delete();
		run_job(16'h0200);
		check_results();
		// four words whose total crosses 2^32 twice
		pending_words.push_back(32'hFFFF_FFF0);
		pending_words.push_back(32'h0000_0025);
		pending_words.push_back(32'h8000_0000);
		pending_words.push_back(32'h7FFF_FFFF);
		run_job(16'h0201);
		check_results();
	endtask

	task automatic test_back_pressure();
		int stalled;
		int waited;
		test_name  = "back_pressure";
		grant_mode = 0;
		stalled    = 0;
		waited     = 0;
		fork
			for (int j = 0; j < 8; j++) begin
				make_words(1 + int'($urandom % 4));
				run_job(VERTEX_ID_BITS'(16'h0300 + j));
			end
			begin
				// a job held off for 10 cycles means the queue is backing up
				while (stalled < 10) begin
					@(negedge clock);
					waited++;
					if (waited > TIMEOUT)
						stop_run("timeout in back_pressure while waiting for a stall");
					stalled = (vertex_valid && !vertex_ready) ? stalled + 1 : 0;
				end
				compare_word({test_name, " early records"}, 32'd0, 32'(got_q.size()));
				grant_mode = 2;
			end
		join
		check_results();
	endtask

	task automatic test_enable_gating();
		logic [31:0] value;
		int          waited;
		test_name  = "enable_gating";
		waited     = 0;
		// park one finished record so the request has something to drop
		grant_mode = 0;
		make_words(2);
		run_job(16'h03ff);
		while (!write_request)
			wait_step(waited, "write_request");
		make_words(6);
		queue_expected(16'h0400);
		send_job(16'h0400, 16'd6);
		send_edges(0, 3);
		cfg_write(CFG_ADDR_CTRL, 32'd0);
		edge_word.data = pending_words[3];
		edge_valid     = 1'b1;
		repeat (4) begin
			check_outputs_low(test_name);
			step();
		end
		edge_valid = 1'b0;
		cfg_read(CFG_ADDR_EDGES, value);
		compare_word({test_name, " frozen edges"}, 32'(edges_sent), value);
		cfg_write(CFG_ADDR_CTRL, 32'd1);
		grant_mode = 1;
		send_edges(3, 6);
		check_results();
	endtask

	task automatic test_config_readback();
		logic [31:0] value;
		logic [31:0] cu_word;
		test_name = "config_readback";
		cu_word   = {24'b0, CU_ID_BITS'(CU_X), CU_ID_BITS'(CU_Y)};
		repeat (2) begin
			cfg_read(CFG_ADDR_EDGES, value);
			compare_word({test_name, " edges"}, 32'(edges_sent), value);
			cfg_read(CFG_ADDR_RESULTS, value);
			compare_word({test_name, " results"}, 32'(results_seen), value);
			cfg_read(CFG_ADDR_CU, value);
			compare_word({test_name, " identity"}, cu_word, value);
			cfg_read(CFG_ADDR_CTRL, value);
			compare_word({test_name, " ctrl"}, 32'd1, value);
			// read-only addresses must ignore these
			cfg_write(CFG_ADDR_CU, 32'hFFFF_FFFF);
			cfg_write(CFG_ADDR_EDGES, 32'd0);
			cfg_write(CFG_ADDR_RESULTS, 32'd0);
		end
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		void'($urandom(SEED));
		rstn         = 1'b0;
		vertex_job   = '0;
		vertex_valid = 1'b0;
		edge_word    = '0;
		edge_valid   = 1'b0;
		write_grant  = 1'b0;
		cfg_req      = '0;
		cfg_valid    = 1'b0;
		grant_mode   = 0;
		edges_sent   = 0;
		results_seen = 0;
		test_name    = "reset";
		repeat (2) @(posedge clock);
		#2;
		rstn = 1'b1;
		step();
		test_reset_disabled();
		test_single_vertex();
		test_degree_zero_and_wrap();
		test_back_pressure();
		test_enable_gating();
		test_config_readback();
		$display("TEST PASS");
		$finish;
	end

endmodule

//--- design/sum_kernel_top.sv
// top level of one sum compute unit
// sets the unit coordinates and result queue depth, then joins the
// control path with the config register block

`timescale 1ns/100ps

module sum_kernel_top
	import sum_kernel_pkg::*;
#(
	parameter int CU_ID_X           = 1,
	parameter int CU_ID_Y           = 1,
	parameter int RESULT_FIFO_DEPTH = 4
) (
	input  logic        clock,
	input  logic        rstn,
	input  vertex_job_t vertex_job,
	input  logic        vertex_valid,
	output logic        vertex_ready,
	input  edge_word_t  edge_word,
	input  logic        edge_valid,
	output logic        edge_ready,
	output logic        write_request,
	input  logic        write_grant,
	output result_rec_t result_out,
	output logic        result_valid,
	input  cfg_req_t    cfg_req,
	input  logic        cfg_valid,
	output logic [31:0] cfg_rdata,
	output logic        cfg_rvalid
);

	logic                 enabled;
	logic [DATA_BITS-1:0] edges_consumed;
	logic [DATA_BITS-1:0] results_issued;

	sum_kernel_control #(
		.CU_ID_X          (CU_ID_X),
		.CU_ID_Y          (CU_ID_Y),
		.RESULT_FIFO_DEPTH(RESULT_FIFO_DEPTH)
	) u_control (
		.clock         (clock),
		.rstn          (rstn),
		.enabled       (enabled),
		.vertex_job    (vertex_job),
		.vertex_valid  (vertex_valid),
		.vertex_ready  (vertex_ready),
		.edge_word     (edge_word),
		.edge_valid    (edge_valid),
		.edge_ready    (edge_ready),
		.write_request (write_request),
		.write_grant   (write_grant),
		.result_out    (result_out),
		.result_valid  (result_valid),
		.edges_consumed(edges_consumed),
		.results_issued(results_issued)
	);

	kernel_config_regs #(
		.CU_ID_X(CU_ID_X),
		.CU_ID_Y(CU_ID_Y)
	) u_config (
		.clock         (clock),
		.rstn          (rstn),
		.cfg_req       (cfg_req),
		.cfg_valid     (cfg_valid),
		.edges_consumed(edges_consumed),
		.results_issued(results_issued),
		.enabled       (enabled),
		.cfg_rdata     (cfg_rdata),
		.cfg_rvalid    (cfg_rvalid)
	);

endmodule

//--- design/kernel_config_regs.sv
// config register block of the sum compute unit
// holds the enable bit and answers reads one cycle after the access;
// the identity word packs the unit's x and y coordinates

`timescale 1ns/100ps

module kernel_config_regs
	import sum_kernel_pkg::*;
#(
	parameter int CU_ID_X = 1,
	parameter int CU_ID_Y = 1
) (
	input  logic                 clock,
	input  logic                 rstn,
	input  cfg_req_t             cfg_req,
	input  logic                 cfg_valid,
	input  logic [DATA_BITS-1:0] edges_consumed,
	input  logic [DATA_BITS-1:0] results_issued,
	output logic                 enabled,
	output logic [31:0]          cfg_rdata,
	output logic                 cfg_rvalid
);

	logic [31:0] cu_word;
	logic [31:0] read_mux;

	// x in bits 7:4, y in bits 3:0
	assign cu_word = {{(32 - 2 * CU_ID_BITS){1'b0}}, CU_ID_BITS'(CU_ID_X), CU_ID_BITS'(CU_ID_Y)};

	//////////////////////////////////////////////////
	// control register
	//////////////////////////////////////////////////

	// only the control address is writable
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else if (cfg_valid && cfg_req.write && cfg_req.addr == CFG_ADDR_CTRL) begin
			enabled <= cfg_req.wdata[0];
		end
	end

	//////////////////////////////////////////////////
	// read path
	//////////////////////////////////////////////////

	always_comb begin
		case (cfg_req.addr)
			CFG_ADDR_CTRL:    read_mux = {31'b0, enabled};
			CFG_ADDR_EDGES:   read_mux = edges_consumed;
			CFG_ADDR_RESULTS: read_mux = results_issued;
			default:          read_mux = cu_word;
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cfg_rvalid <= 1'b0;
		end else begin
			cfg_rvalid <= cfg_valid && !cfg_req.write;
		end
	end

	always_ff @(posedge clock) begin
		if (cfg_valid && !cfg_req.write) begin
			cfg_rdata <= read_mux;
		end
	end

endmodule

//--- design/sum_kernel_control.sv
// datapath control of the sum compute unit
// gates all traffic with the enable bit, counts consumed edges and
// issued results, queues records and drives the write-bus request;
// a granted request pops one record onto result_out for one cycle

`timescale 1ns/100ps

module sum_kernel_control
	import sum_kernel_pkg::*;
#(
	parameter int CU_ID_X           = 1,
	parameter int CU_ID_Y           = 1,
	parameter int RESULT_FIFO_DEPTH = 4
) (
	input  logic                 clock,
	input  logic                 rstn,
	input  logic                 enabled,
	input  vertex_job_t          vertex_job,
	input  logic                 vertex_valid,
	output logic                 vertex_ready,
	input  edge_word_t           edge_word,
	input  logic                 edge_valid,
	output logic                 edge_ready,
	output logic                 write_request,
	input  logic                 write_grant,
	output result_rec_t          result_out,
	output logic                 result_valid,
	output logic [DATA_BITS-1:0] edges_consumed,
	output logic [DATA_BITS-1:0] results_issued
);

	logic        push;
	result_rec_t push_rec;
	result_rec_t fifo_head;
	logic        fifo_full;
	logic        fifo_alfull;
	logic        fifo_empty;
	logic        request_q;
	logic        pop;

	//////////////////////////////////////////////////
	// accumulator and result queue
	//////////////////////////////////////////////////

	edge_sum_accumulator #(
		.CU_ID_X(CU_ID_X),
		.CU_ID_Y(CU_ID_Y)
	) u_accumulator (
		.clock       (clock),
		.rstn        (rstn),
		.enabled     (enabled),
		.fifo_alfull (fifo_alfull),
		.vertex_job  (vertex_job),
		.vertex_valid(vertex_valid),
		.vertex_ready(vertex_ready),
		.edge_word   (edge_word),
		.edge_valid  (edge_valid),
		.edge_ready  (edge_ready),
		.push        (push),
		.push_rec    (push_rec)
	);

	result_fifo #(
		.WIDTH($bits(result_rec_t)),
		.DEPTH(RESULT_FIFO_DEPTH)
	) u_result_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (push && !fifo_full),
		.data_in (push_rec),
		.pop     (pop),
		.data_out(fifo_head),
		.full    (fifo_full),
		.alfull  (fifo_alfull),
		.empty   (fifo_empty)
	);

	//////////////////////////////////////////////////
	// write bus
	//////////////////////////////////////////////////

	// request drops for one cycle after each pop so a single
	// remaining record is never granted twice
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			request_q <= 1'b0;
		end else begin
			request_q <= enabled && !fifo_empty && !pop;
		end
	end

	assign write_request = request_q && enabled;
	// grant without request is ignored
	assign pop           = write_grant && write_request;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= pop;
		end
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			result_out <= fifo_head;
		end
	end

	//////////////////////////////////////////////////
	// activity counters
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edges_consumed <= '0;
			results_issued <= '0;
		end else begin
			if (edge_valid && edge_ready) begin
				edges_consumed <= edges_consumed + 1'b1;
			end
			if (pop) begin
				results_issued <= results_issued + 1'b1;
			end
		end
	end

endmodule

//--- design/edge_sum_accumulator.sv
// per-vertex accumulator: takes one vertex job, consumes its edge words,
// keeps a wrapping 32-bit sum and presents one result record per job
// push is high for the single cycle in which the record is complete

`timescale 1ns/100ps

module edge_sum_accumulator
	import sum_kernel_pkg::*;
#(
	parameter int CU_ID_X = 1,
	parameter int CU_ID_Y = 1
) (
	input  logic        clock,
	input  logic        rstn,
	input  logic        enabled,
	input  logic        fifo_alfull,
	input  vertex_job_t vertex_job,
	input  logic        vertex_valid,
	output logic        vertex_ready,
	input  edge_word_t  edge_word,
	input  logic        edge_valid,
	output logic        edge_ready,
	output logic        push,
	output result_rec_t push_rec
);

	vertex_job_t                job_q;
	logic                       active;
	logic [EDGE_COUNT_BITS-1:0] edge_cnt;
	logic [DATA_BITS-1:0]       sum;
	logic                       job_take;
	logic                       edge_take;
	logic                       all_edges;

	//////////////////////////////////////////////////
	// handshakes
	//////////////////////////////////////////////////

	// no new job while the result queue is close to full
	assign vertex_ready = enabled && !active && !fifo_alfull;
	assign all_edges    = (edge_cnt == job_q.out_degree);
	assign edge_ready   = enabled && active && (edge_cnt < job_q.out_degree);

	assign job_take  = vertex_valid && vertex_ready;
	assign edge_take = edge_valid && edge_ready;

	// record complete once every expected edge has been counted
	assign push = enabled && active && all_edges;

	//////////////////////////////////////////////////
	// job latch
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (job_take) begin
			job_q <= vertex_job;
		end
	end

	//////////////////////////////////////////////////
	// count and sum
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			active   <= 1'b0;
			edge_cnt <= '0;
			sum      <= '0;
		end else begin
			if (job_take) begin
				active <= 1'b1;
			end else if (push) begin
				// back to idle, clean for the next job
				active   <= 1'b0;
				edge_cnt <= '0;
				sum      <= '0;
			end else if (edge_take) begin
				edge_cnt <= edge_cnt + 1'b1;
				// two's complement wrap on overflow
				sum      <= sum + edge_word.data;
			end
		end
	end

	// record stamped with this unit's coordinates
	always_comb begin
		push_rec            = '0;
		push_rec.vertex_id  = job_q.vertex_id;
		push_rec.cu_id_x    = CU_ID_BITS'(CU_ID_X);
		push_rec.cu_id_y    = CU_ID_BITS'(CU_ID_Y);
		push_rec.edge_count = edge_cnt;
		push_rec.sum        = sum;
	end

endmodule

//--- design/result_fifo.sv
// synchronous ring-buffer FIFO for finished result records
// show-ahead read: data_out holds the head entry while not empty,
// pop removes it on the next rising edge

`timescale 1ns/100ps

module result_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             full,
	output logic             alfull,
	output logic             empty
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]    mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic                do_push;
	logic                do_pop;

	// push into a full buffer or pop from an empty one is dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_BITS'(do_push) - CNT_BITS'(do_pop);
		end
	end

	assign data_out = mem[rd_ptr];
	assign empty    = (count == '0);
	assign full     = (count == CNT_BITS'(DEPTH));
	// at most one free slot left
	assign alfull   = (count >= CNT_BITS'(DEPTH - 1));

endmodule

//--- design/sum_kernel_pkg.sv
// shared widths, record types and register map for the sum compute unit
// imported by every module that handles jobs, edge words, results or
// config accesses

package sum_kernel_pkg;

	//////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////

	parameter int VERTEX_ID_BITS  = 16;
	parameter int EDGE_COUNT_BITS = 16;
	parameter int DATA_BITS       = 32;
	parameter int CU_ID_BITS      = 4;

	//////////////////////////////////////////////////
	// stream records
	//////////////////////////////////////////////////

	// out_degree is the number of edge words that follow the job
	typedef struct packed {
		logic [VERTEX_ID_BITS-1:0]  vertex_id;
		logic [EDGE_COUNT_BITS-1:0] out_degree;
	} vertex_job_t;

	typedef struct packed {
		logic [DATA_BITS-1:0] data;
	} edge_word_t;

	typedef struct packed {
		logic [VERTEX_ID_BITS-1:0]  vertex_id;
		logic [CU_ID_BITS-1:0]      cu_id_x;
		logic [CU_ID_BITS-1:0]      cu_id_y;
		logic [EDGE_COUNT_BITS-1:0] edge_count;
		logic [DATA_BITS-1:0]       sum;
	} result_rec_t;

	//////////////////////////////////////////////////
	// config access and register map
	//////////////////////////////////////////////////

	typedef struct packed {
		logic        write;
		logic [1:0]  addr;
		logic [31:0] wdata;
	} cfg_req_t;

	parameter logic [1:0] CFG_ADDR_CTRL    = 2'd0;
	parameter logic [1:0] CFG_ADDR_EDGES   = 2'd1;
	parameter logic [1:0] CFG_ADDR_RESULTS = 2'd2;
	parameter logic [1:0] CFG_ADDR_CU      = 2'd3;

endpackage
